//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // cpu word and line geometry
    localparam int word_w         = 16;
    localparam int words_per_line = 4;
    localparam int num_sets       = 2;
    localparam int num_ways       = 2;

    // address split, from high to low: tag, index, offset
    localparam int offset_w = 2;
    localparam int index_w  = 1;
    localparam int tag_w    = word_w - index_w - offset_w;

    // queue depths
    localparam int req_depth    = 2;
    localparam int victim_depth = 2;

    // tag entry layout: tag in the low bits, then valid, dirty, recent
    localparam int te_valid_bit  = tag_w;
    localparam int te_dirty_bit  = tag_w + 1;
    localparam int te_recent_bit = tag_w + 2;

    // request and victim payload layout
    localparam int req_write_bit = 2 * word_w;
    localparam int req_addr_lo   = word_w;
    localparam int victim_addr_lo = words_per_line * word_w;

    typedef logic [word_w-1:0]                word_t;
    typedef logic [words_per_line*word_w-1:0] line_t;
    typedef logic [tag_w-1:0]                 tag_t;
    typedef logic [index_w-1:0]               index_t;
    typedef logic [offset_w-1:0]              offset_t;
    typedef logic [tag_w+2:0]                 tag_entry_t;
    typedef logic [2*word_w:0]                cpu_req_t;
    typedef logic [word_w+words_per_line*word_w-1:0] victim_t;

    function automatic word_t get_word(line_t line, offset_t off);
        return line[off*word_w +: word_w];
    endfunction

    // replace one word of a line, the rest is kept
    function automatic line_t set_word(line_t line, offset_t off, word_t w);
        line_t merged;
        merged = line;
        merged[off*word_w +: word_w] = w;
        return merged;
    endfunction

    function automatic tag_entry_t make_entry(tag_t tag, logic dirty);
        tag_entry_t te;
        te = '0;
        te[tag_w-1:0] = tag;
        te[te_valid_bit] = 1'b1;
        te[te_dirty_bit] = dirty;
        te[te_recent_bit] = 1'b1;
        return te;
    endfunction

endpackage

`default_nettype wire

//--- src/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter type payload_t = logic,
    parameter int depth = 2
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    payload_t store [depth];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;
    logic     push;
    logic     pop;

    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != cnt_t'(depth));
    assign out_valid = (count != '0);
    assign out_data  = store[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage itself is not reset
    always_ff @(posedge clk) begin
        if (push) begin
            store[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- src/cache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module cache_arrays (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cache_pkg::index_t     index,
    input  logic                  tag_we,
    input  logic                  data_we,
    input  cache_pkg::tag_entry_t tag_wdata  [cache_pkg::num_ways],
    input  cache_pkg::line_t      data_wdata [cache_pkg::num_ways],
    output cache_pkg::tag_entry_t tag_rdata  [cache_pkg::num_ways],
    output cache_pkg::line_t      data_rdata [cache_pkg::num_ways]
);

    // one entry per way and set
    cache_pkg::tag_entry_t tag_mem  [cache_pkg::num_ways][cache_pkg::num_sets];
    cache_pkg::line_t      data_mem [cache_pkg::num_ways][cache_pkg::num_sets];

    // tags are cleared on reset so every line starts invalid and not recent
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                for (int s = 0; s < cache_pkg::num_sets; s++) begin
                    tag_mem[w][s] <= '0;
                end
            end
        end else if (tag_we) begin
            // both ways are written together, recent bits move as a pair
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                tag_mem[w][index] <= tag_wdata[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                data_mem[w][index] <= data_wdata[w];
            end
        end
    end

    // combinational read of the addressed set
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            tag_rdata[w]  = tag_mem[w][index];
            data_rdata[w] = data_mem[w][index];
        end
    end

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    // head of the request queue
    input  logic                  req_valid,
    output logic                  req_ready,
    input  cache_pkg::cpu_req_t   req,
    output logic                  cpu_resp_valid,
    output cache_pkg::word_t      cpu_resp_rdata,
    // array access
    output cache_pkg::index_t     index,
    output logic                  tag_we,
    output logic                  data_we,
    output cache_pkg::tag_entry_t tag_wdata  [cache_pkg::num_ways],
    output cache_pkg::line_t      data_wdata [cache_pkg::num_ways],
    input  cache_pkg::tag_entry_t tag_rdata  [cache_pkg::num_ways],
    input  cache_pkg::line_t      data_rdata [cache_pkg::num_ways],
    // victim buffer and fill path
    output logic                  victim_valid,
    input  logic                  victim_ready,
    output cache_pkg::victim_t    victim,
    output logic                  fill_valid,
    input  logic                  fill_ready,
    output cache_pkg::word_t      fill_addr,
    input  logic                  mem_resp_valid,
    input  cache_pkg::line_t      mem_resp_rline
);

    typedef enum logic [1:0] {
        s_lookup,
        s_victim,
        s_fill_req,
        s_fill_wait
    } state_t;

    state_t state;
    state_t state_next;

    logic                req_write;
    cache_pkg::word_t    req_addr;
    cache_pkg::word_t    req_wdata;
    cache_pkg::tag_t     req_tag;
    cache_pkg::offset_t  req_offset;

    logic [cache_pkg::num_ways-1:0] hit;
    logic hit_any;
    logic hit_way;
    logic repl_way;
    logic repl_q;
    logic repl_dirty;
    cache_pkg::line_t fill_line;

    // unpack the request
    assign req_write  = req[cache_pkg::req_write_bit];
    assign req_addr   = req[cache_pkg::req_addr_lo +: cache_pkg::word_w];
    assign req_wdata  = req[cache_pkg::word_w-1:0];
    assign req_tag    = req_addr[cache_pkg::word_w-1 -: cache_pkg::tag_w];
    assign index      = req_addr[cache_pkg::offset_w +: cache_pkg::index_w];
    assign req_offset = req_addr[cache_pkg::offset_w-1:0];

    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            hit[w] = tag_rdata[w][cache_pkg::te_valid_bit] &&
                     (tag_rdata[w][cache_pkg::tag_w-1:0] == req_tag);
        end
    end

    assign hit_any = |hit;
    assign hit_way = hit[1];

    // way 0 only when it is the sole way with a clear recent bit
    assign repl_way = !(tag_rdata[1][cache_pkg::te_recent_bit] &&
                        !tag_rdata[0][cache_pkg::te_recent_bit]);
    assign repl_dirty = tag_rdata[repl_way][cache_pkg::te_valid_bit] &&
                        tag_rdata[repl_way][cache_pkg::te_dirty_bit];

    // evicted line goes out at its own line address
    assign victim = {tag_rdata[repl_q][cache_pkg::tag_w-1:0], index,
                     {cache_pkg::offset_w{1'b0}}, data_rdata[repl_q]};
    assign fill_addr = {req_tag, index, {cache_pkg::offset_w{1'b0}}};

    // a write miss merges its word into the returned line
    assign fill_line = req_write ?
                       cache_pkg::set_word(mem_resp_rline, req_offset, req_wdata) :
                       mem_resp_rline;

    always_comb begin
        state_next     = state;
        req_ready      = 1'b0;
        cpu_resp_valid = 1'b0;
        cpu_resp_rdata = cache_pkg::get_word(data_rdata[hit_way], req_offset);
        tag_we         = 1'b0;
        data_we        = 1'b0;
        tag_wdata      = tag_rdata;
        data_wdata     = data_rdata;
        victim_valid   = 1'b0;
        fill_valid     = 1'b0;

        case (state)
            s_lookup: begin
                if (req_valid) begin
                    if (hit_any) begin
                        req_ready      = 1'b1;
                        cpu_resp_valid = 1'b1;
                        tag_we         = 1'b1;
                        tag_wdata[hit_way][cache_pkg::te_recent_bit]  = 1'b1;
                        tag_wdata[!hit_way][cache_pkg::te_recent_bit] = 1'b0;
                        if (req_write) begin
                            data_we = 1'b1;
                            data_wdata[hit_way] = cache_pkg::set_word(
                                data_rdata[hit_way], req_offset, req_wdata);
                            tag_wdata[hit_way][cache_pkg::te_dirty_bit] = 1'b1;
                        end
                    end else if (repl_dirty) begin
                        // wait here while the victim buffer is full
                        if (victim_ready) begin
                            state_next = s_victim;
                        end
                    end else begin
                        state_next = s_fill_req;
                    end
                end
            end

            s_victim: begin
                victim_valid = 1'b1;
                if (victim_ready) begin
                    state_next = s_fill_req;
                end
            end

            s_fill_req: begin
                fill_valid = 1'b1;
                if (fill_ready) begin
                    state_next = s_fill_wait;
                end
            end

            s_fill_wait: begin
                cpu_resp_rdata = cache_pkg::get_word(mem_resp_rline, req_offset);
                if (mem_resp_valid) begin
                    req_ready      = 1'b1;
                    cpu_resp_valid = 1'b1;
                    tag_we         = 1'b1;
                    data_we        = 1'b1;
                    data_wdata[repl_q] = fill_line;
                    tag_wdata[repl_q]  = cache_pkg::make_entry(req_tag, req_write);
                    tag_wdata[!repl_q][cache_pkg::te_recent_bit] = 1'b0;
                    state_next = s_lookup;
                end
            end

            default: state_next = s_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= s_lookup;
        end else begin
            state <= state_next;
        end
    end

    // replacement way is frozen once the miss leaves lookup
    always_ff @(posedge clk) begin
        if (state == s_lookup && state_next != s_lookup) begin
            repl_q <= repl_way;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  logic               clk,
    input  logic               reset_n,
    // victim buffer head
    input  logic               victim_valid,
    output logic               victim_ready,
    input  cache_pkg::victim_t victim,
    // fill read from the controller
    input  logic               fill_valid,
    output logic               fill_ready,
    input  cache_pkg::word_t   fill_addr,
    // memory request channel
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    output logic               mem_req_write,
    output cache_pkg::word_t   mem_req_addr,
    output cache_pkg::line_t   mem_req_wline
);

    logic slot_free;

    // slot can take new work when empty or being accepted this cycle
    assign slot_free = !mem_req_valid || mem_req_ready;

    // victim writes always win, so a fill never overtakes a write-back
    assign victim_ready = slot_free;
    assign fill_ready   = slot_free && !victim_valid;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mem_req_valid <= 1'b0;
        end else if (slot_free) begin
            mem_req_valid <= victim_valid || fill_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_free) begin
            if (victim_valid) begin
                mem_req_write <= 1'b1;
                mem_req_addr  <= victim[cache_pkg::victim_addr_lo +: cache_pkg::word_w];
                mem_req_wline <= victim[cache_pkg::victim_addr_lo-1:0];
            end else if (fill_valid) begin
                // write data is left as is for a read
                mem_req_write <= 1'b0;
                mem_req_addr  <= fill_addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/data_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache_top (
    input  logic             clk,
    input  logic             reset_n,
    // cpu side
    input  logic             cpu_req_valid,
    output logic             cpu_req_ready,
    input  logic             cpu_req_write,
    input  cache_pkg::word_t cpu_req_addr,
    input  cache_pkg::word_t cpu_req_wdata,
    output logic             cpu_resp_valid,
    output cache_pkg::word_t cpu_resp_rdata,
    // memory side
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output logic             mem_req_write,
    output cache_pkg::word_t mem_req_addr,
    output cache_pkg::line_t mem_req_wline,
    input  logic             mem_resp_valid,
    input  cache_pkg::line_t mem_resp_rline
);

    logic                  head_valid;
    logic                  head_ready;
    cache_pkg::cpu_req_t   head_req;

    cache_pkg::index_t     index;
    logic                  tag_we;
    logic                  data_we;
    cache_pkg::tag_entry_t tag_wdata  [cache_pkg::num_ways];
    cache_pkg::line_t      data_wdata [cache_pkg::num_ways];
    cache_pkg::tag_entry_t tag_rdata  [cache_pkg::num_ways];
    cache_pkg::line_t      data_rdata [cache_pkg::num_ways];

    logic                  vin_valid;
    logic                  vin_ready;
    cache_pkg::victim_t    vin_data;
    logic                  vout_valid;
    logic                  vout_ready;
    cache_pkg::victim_t    vout_data;

    logic                  fill_valid;
    logic                  fill_ready;
    cache_pkg::word_t      fill_addr;

    // cpu request packs as write flag, address, write data
    req_queue #(
        .payload_t (cache_pkg::cpu_req_t),
        .depth     (cache_pkg::req_depth)
    ) u_req_q (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (cpu_req_valid),
        .in_ready  (cpu_req_ready),
        .in_data   ({cpu_req_write, cpu_req_addr, cpu_req_wdata}),
        .out_valid (head_valid),
        .out_ready (head_ready),
        .out_data  (head_req)
    );

    cache_ctrl u_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .req_valid      (head_valid),
        .req_ready      (head_ready),
        .req            (head_req),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_rdata (cpu_resp_rdata),
        .index          (index),
        .tag_we         (tag_we),
        .data_we        (data_we),
        .tag_wdata      (tag_wdata),
        .data_wdata     (data_wdata),
        .tag_rdata      (tag_rdata),
        .data_rdata     (data_rdata),
        .victim_valid   (vin_valid),
        .victim_ready   (vin_ready),
        .victim         (vin_data),
        .fill_valid     (fill_valid),
        .fill_ready     (fill_ready),
        .fill_addr      (fill_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rline (mem_resp_rline)
    );

    cache_arrays u_arrays (
        .clk        (clk),
        .reset_n    (reset_n),
        .index      (index),
        .tag_we     (tag_we),
        .data_we    (data_we),
        .tag_wdata  (tag_wdata),
        .data_wdata (data_wdata),
        .tag_rdata  (tag_rdata),
        .data_rdata (data_rdata)
    );

    // victim buffer
    req_queue #(
        .payload_t (cache_pkg::victim_t),
        .depth     (cache_pkg::victim_depth)
    ) u_victim_q (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (vin_valid),
        .in_ready  (vin_ready),
        .in_data   (vin_data),
        .out_valid (vout_valid),
        .out_ready (vout_ready),
        .out_data  (vout_data)
    );

    mem_port u_mem_port (
        .clk           (clk),
        .reset_n       (reset_n),
        .victim_valid  (vout_valid),
        .victim_ready  (vout_ready),
        .victim        (vout_data),
        .fill_valid    (fill_valid),
        .fill_ready    (fill_ready),
        .fill_addr     (fill_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wline (mem_req_wline)
    );

endmodule

`default_nettype wire

//--- sim/tb_data_cache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_cache_assert (
    input logic             clk,
    input logic             reset_n,
    input logic             mem_req_valid,
    input logic             mem_req_ready,
    input logic             mem_req_write,
    input cache_pkg::word_t mem_req_addr,
    input cache_pkg::line_t mem_req_wline,
    input logic             mem_resp_valid
);

    logic read_open;
    logic reset_seen;

    // a fill read stays open until memory answers it
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            read_open <= 1'b0;
        end else if (mem_req_valid && mem_req_ready && !mem_req_write) begin
            read_open <= 1'b1;
        end else if (mem_resp_valid) begin
            read_open <= 1'b0;
        end
    end

    // registers have seen at least one reset edge
    always_ff @(posedge clk) begin
        reset_seen <= !reset_n;
    end

    req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write) &&
            $stable(mem_req_addr) && (!mem_req_write || $stable(mem_req_wline)))
        else $error("memory request changed while stalled");

    quiet_in_reset: assert property (@(posedge clk)
        reset_seen && !reset_n |-> !mem_req_valid)
        else $error("memory request valid during reset");

    resp_after_read: assert property (@(posedge clk) disable iff (!reset_n)
        mem_resp_valid |-> read_open)
        else $error("memory response without an outstanding read");

endmodule

bind data_cache_top tb_data_cache_assert u_hs_assert (
    .clk            (clk),
    .reset_n        (reset_n),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wline  (mem_req_wline),
    .mem_resp_valid (mem_resp_valid)
);

`default_nettype wire

//--- sim/tb_data_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_cache;

    logic             clk;
    logic             reset_n;
    logic             cpu_req_valid;
    logic             cpu_req_ready;
    logic             cpu_req_write;
    cache_pkg::word_t cpu_req_addr;
    cache_pkg::word_t cpu_req_wdata;
    logic             cpu_resp_valid;
    cache_pkg::word_t cpu_resp_rdata;
    logic             mem_req_valid;
    logic             mem_req_ready = 1'b0;
    logic             mem_req_write;
    cache_pkg::word_t mem_req_addr;
    cache_pkg::line_t mem_req_wline;
    logic             mem_resp_valid = 1'b0;
    cache_pkg::line_t mem_resp_rline = '0;

    // four words per pattern line: op, address, write data, expected read data
    cache_pkg::word_t pat_mem [128];
    int               num_pat = 0;
    int               issued [$];
    int               answered = 0;
    int unsigned      cycles = 0;
    int unsigned      cycle_limit = 0;

    // memory model contents and the flat reference seen by the cpu
    cache_pkg::word_t mem_words [cache_pkg::word_t];
    cache_pkg::word_t ref_words [cache_pkg::word_t];

    // expected tag state, one entry per set and way
    cache_pkg::tag_t  mdl_tag    [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             mdl_valid  [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             mdl_dirty  [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             mdl_recent [cache_pkg::num_sets][cache_pkg::num_ways];

    // memory traffic seen since the last cpu response
    cache_pkg::word_t fill_seen [$];
    cache_pkg::word_t victim_seen [$];

    logic [31:0]      rng = 32'd91;
    logic             rd_pending = 1'b0;
    int               rd_wait = 0;
    cache_pkg::word_t rd_addr = '0;
    logic             ready_next = 1'b0;
    logic             resp_next = 1'b0;
    cache_pkg::line_t rline_next = '0;

    data_cache_top dut_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_req_write  (cpu_req_write),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_wdata  (cpu_req_wdata),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_rdata (cpu_resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wline  (mem_req_wline),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rline (mem_resp_rline)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // untouched memory holds a value tied to every address bit
    function automatic cache_pkg::word_t init_word(cache_pkg::word_t a);
        return a ^ 16'ha5a5;
    endfunction

    function automatic cache_pkg::line_t ref_line(cache_pkg::word_t addr);
        cache_pkg::line_t l;
        cache_pkg::word_t a;
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            a = addr;
            a[cache_pkg::offset_w-1:0] = cache_pkg::offset_t'(i);
            l[i*cache_pkg::word_w +: cache_pkg::word_w] =
                ref_words.exists(a) ? ref_words[a] : init_word(a);
        end
        return l;
    endfunction

    function automatic cache_pkg::line_t mem_line(cache_pkg::word_t addr);
        cache_pkg::line_t l;
        cache_pkg::word_t a;
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            a = addr;
            a[cache_pkg::offset_w-1:0] = cache_pkg::offset_t'(i);
            l[i*cache_pkg::word_w +: cache_pkg::word_w] =
                mem_words.exists(a) ? mem_words[a] : init_word(a);
        end
        return l;
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string name, cache_pkg::word_t exp, cache_pkg::word_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_line(string name, cache_pkg::line_t exp, cache_pkg::line_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // a retired request predicts its fill and victim traffic from the tag state
    task automatic replay_tags(int idx, logic wr, cache_pkg::word_t a);
        cache_pkg::index_t set_i;
        cache_pkg::tag_t   tag_i;
        cache_pkg::word_t  line_a;
        int                way;
        int                n_fill;
        int                n_victim;
        set_i    = a[cache_pkg::offset_w +: cache_pkg::index_w];
        tag_i    = a[cache_pkg::word_w-1 -: cache_pkg::tag_w];
        line_a   = {a[cache_pkg::word_w-1:cache_pkg::offset_w], {cache_pkg::offset_w{1'b0}}};
        way      = -1;
        n_fill   = 0;
        n_victim = 0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (mdl_valid[set_i][w] && mdl_tag[set_i][w] == tag_i) begin
                way = w;
            end
        end
        if (way < 0) begin
            // the way not used last, way 1 when neither was
            way    = mdl_recent[set_i][1] ? 0 : 1;
            n_fill = 1;
            if (mdl_valid[set_i][way] && mdl_dirty[set_i][way]) begin
                n_victim = 1;
            end
        end
        if (fill_seen.size() != n_fill) begin
            fail_run($sformatf("Error: pattern %0d fill reads expected %0d actual %0d",
                               idx, n_fill, fill_seen.size()));
        end else if (victim_seen.size() != n_victim) begin
            fail_run($sformatf("Error: pattern %0d victim writes expected %0d actual %0d",
                               idx, n_victim, victim_seen.size()));
        end else begin
            if (n_victim == 1) begin
                check_word($sformatf("pattern %0d victim address", idx),
                           {mdl_tag[set_i][way], set_i, {cache_pkg::offset_w{1'b0}}},
                           victim_seen.pop_front());
            end
            if (n_fill == 1) begin
                check_word($sformatf("pattern %0d fill address", idx),
                           line_a, fill_seen.pop_front());
            end
        end
        if (n_fill == 1) begin
            mdl_tag[set_i][way]   = tag_i;
            mdl_valid[set_i][way] = 1'b1;
            mdl_dirty[set_i][way] = 1'b0;
        end
        if (wr) begin
            mdl_dirty[set_i][way] = 1'b1;
        end
        mdl_recent[set_i][way]     = 1'b1;
        mdl_recent[set_i][1 - way] = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
                               cycles, answered, num_pat));
        end
    end

    // memory model, decisions made on the rising edge and driven on the falling one
    always @(posedge clk) begin
        cache_pkg::word_t a;
        resp_next = 1'b0;
        if (reset_n && mem_req_valid && mem_req_ready) begin
            if (mem_req_write) begin
                check_line($sformatf("victim write %h", mem_req_addr),
                           ref_line(mem_req_addr), mem_req_wline);
                for (int i = 0; i < cache_pkg::words_per_line; i++) begin
                    a = mem_req_addr;
                    a[cache_pkg::offset_w-1:0] = cache_pkg::offset_t'(i);
                    mem_words[a] = mem_req_wline[i*cache_pkg::word_w +: cache_pkg::word_w];
                end
                victim_seen.push_back(mem_req_addr);
            end else if (rd_pending) begin
                fail_run("a second fill read was issued before the first one returned");
            end else begin
                // any write-back of this line must already be in memory
                check_line($sformatf("fill read %h", mem_req_addr),
                           ref_line(mem_req_addr), mem_line(mem_req_addr));
                fill_seen.push_back(mem_req_addr);
                rng = xorshift32(rng);
                rd_wait = 1 + int'(rng % 4);
                rd_addr = mem_req_addr;
                rd_pending = 1'b1;
            end
        end
        if (rd_pending) begin
            if (rd_wait == 1) begin
                resp_next = 1'b1;
                rline_next = mem_line(rd_addr);
                rd_pending = 1'b0;
            end else begin
                rd_wait = rd_wait - 1;
            end
        end
        // about one cycle in four is a stall
        rng = xorshift32(rng);
        ready_next = (rng[1:0] != 2'b00);
    end

    always @(negedge clk) begin
        mem_req_ready  = ready_next;
        mem_resp_valid = resp_next;
        mem_resp_rline = rline_next;
    end

    // responses retire requests in order and update the reference
    always @(posedge clk) begin
        int               idx;
        cache_pkg::word_t a;
        cache_pkg::line_t l;
        if (reset_n && cpu_resp_valid) begin
            if (issued.size() == 0) begin
                fail_run("a cpu response arrived with no request outstanding");
            end else begin
                idx = issued.pop_front();
                a = pat_mem[4*idx+1];
                replay_tags(idx, pat_mem[4*idx] == 16'h0001, a);
                if (pat_mem[4*idx] == 16'h0001) begin
                    ref_words[a] = pat_mem[4*idx+2];
                end else begin
                    l = ref_line(a);
                    check_word($sformatf("pattern %0d read %h vs reference", idx, a),
                               l[a[cache_pkg::offset_w-1:0]*cache_pkg::word_w +: cache_pkg::word_w],
                               cpu_resp_rdata);
                    check_word($sformatf("pattern %0d read %h vs file", idx, a),
                               pat_mem[4*idx+3], cpu_resp_rdata);
                end
                answered = answered + 1;
            end
        end
    end

    initial begin
        reset_n       = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req_write = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                mdl_tag[s][w]    = '0;
                mdl_valid[s][w]  = 1'b0;
                mdl_dirty[s][w]  = 1'b0;
                mdl_recent[s][w] = 1'b0;
            end
        end
        for (int i = 0; i < $size(pat_mem); i++) begin
            pat_mem[i] = 16'hffff;
        end
        $readmemh("sim/cache_patterns.txt", pat_mem);
        while (num_pat < $size(pat_mem) / 4 && pat_mem[4*num_pat] != 16'hffff) begin
            num_pat = num_pat + 1;
        end
        if (num_pat == 0) begin
            fail_run("no patterns were read from sim/cache_patterns.txt");
        end
        cycle_limit = 200 * num_pat;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        for (int i = 0; i < num_pat; i++) begin
            @(negedge clk);
            cpu_req_valid = 1'b1;
            cpu_req_write = (pat_mem[4*i] == 16'h0001);
            cpu_req_addr  = pat_mem[4*i+1];
            cpu_req_wdata = pat_mem[4*i+2];
            // ready is registered, its value here holds through the next rising edge
            while (!cpu_req_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            issued.push_back(i);
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;

        while (answered < num_pat) begin
            @(posedge clk);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/cache_patterns.txt
// columns: op (0 read, 1 write), word address, write data, expected read data
// memory starts as address xor a5a5, expected data is 0000 for writes
// read miss then read hit in one line
0 0001 0000 a5a4
0 0003 0000 a5a6
// write hit, then read back
1 0002 1234 0000
0 0002 0000 1234
// third tag in set 0 evicts the dirty line
0 0010 0000 a5b5
0 0021 0000 a584
0 0002 0000 1234
0 0021 0000 a584
// write miss in set 1
1 0006 beef 0000
0 0006 0000 beef
0 0005 0000 a5a0
// mixed traffic in set 1 with dirty evictions
1 000d 5555 0000
1 0014 7777 0000
0 000d 0000 5555
0 0006 0000 beef
0 0016 0000 a5b3
0 0014 0000 7777
0 000c 0000 a5a9
0 000d 0000 5555

//--- sources.f
src/cache_pkg.sv
src/req_queue.sv
src/cache_arrays.sv
src/cache_ctrl.sv
src/mem_port.sv
src/data_cache_top.sv
sim/tb_data_cache_assert.sv
sim/tb_data_cache.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_data_cache
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
